// File: design/tft_defines.svh
`ifndef TFT_DEFINES_SVH
`define TFT_DEFINES_SVH

// width of a bus word and of a command word
`define TFT_DATA_W 32

// bits shifted out per chip select window
`define TFT_FRAME_BITS 16

// processor bus address width
`define TFT_REG_ADDR_W 4

// command bit that turns the word into a delay
`define TFT_DELAY_BIT 31

`endif

// File: design/tft_bus_pkg.sv
`include "tft_defines.svh"

package tft_bus_pkg;

    // register offsets on the processor bus
    typedef enum logic [`TFT_REG_ADDR_W-1:0] {
        REG_CMD    = 4'd0,
        REG_RXDATA = 4'd4,
        REG_STATUS = 4'd8
    } reg_addr_e;

    // bit positions inside the status word
    typedef enum int unsigned {
        ST_BUSY     = 0,
        ST_RX_VALID = 1,
        ST_OVERFLOW = 2
    } status_bit_e;

endpackage

// File: design/tft_spi_pkg.sv
package tft_spi_pkg;

    // engine states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        LOAD  = 3'd1,
        SHIFT = 3'd2,
        READ  = 3'd3,
        DELAY = 3'd4
    } spi_state_e;

    // RA8875 upper byte of a frame
    // selects command/data and write/read
    typedef enum logic [7:0] {
        DATA_WRITE  = 8'h00,
        DATA_READ   = 8'h40,
        CMD_WRITE   = 8'h80,
        STATUS_READ = 8'hC0
    } ra8875_cmd_e;

endpackage

// File: design/tft_mmio_if.sv
`timescale 1ns/10ps
`include "tft_defines.svh"

interface tft_mmio_if (
    input logic clk
);

    // register block to engine
    logic [`TFT_DATA_W-1:0] mosi_data;
    logic                   write;
    logic                   read;

    // engine to register block, byte sits in bits 7:0
    logic [`TFT_DATA_W-1:0] miso_data;
    logic                   ack;

    modport regs (
        input  clk,
        input  miso_data,
        input  ack,
        output mosi_data,
        output write,
        output read
    );

    modport engine (
        input  clk,
        input  mosi_data,
        input  write,
        input  read,
        output miso_data,
        output ack
    );

endinterface

// File: design/tft_mmio_regs.sv
`timescale 1ns/10ps
`include "tft_defines.svh"

module tft_mmio_regs import tft_bus_pkg::*, tft_spi_pkg::*; (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [`TFT_REG_ADDR_W-1:0] bus_addr,
    input  logic [`TFT_DATA_W-1:0]     bus_wdata,
    input  logic                       bus_wen,
    input  logic                       bus_ren,
    output logic [`TFT_DATA_W-1:0]     bus_rdata,
    tft_mmio_if.regs                   mmio
);

    // handoff sequence toward the engine
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_CMD   = 2'd1,
        PH_FETCH = 2'd2
    } phase_e;

    phase_e                 phase;
    logic                   slot_full;
    logic [`TFT_DATA_W-1:0] slot_data;
    logic [7:0]             launched_code;
    logic                   launched_delay;
    logic                   ack_q;
    logic                   ack_fall;
    logic                   fetch_due;
    logic                   cmd_wr;
    logic                   rx_rd;
    logic                   st_rd;
    logic                   busy;
    logic [7:0]             rx_byte;
    logic                   rx_valid;
    logic                   overflow;
    logic [`TFT_DATA_W-1:0] status_word;

    assign cmd_wr = bus_wen && (bus_addr == REG_CMD);
    assign rx_rd  = bus_ren && (bus_addr == REG_RXDATA);
    assign st_rd  = bus_ren && (bus_addr == REG_STATUS);

    assign ack_fall  = ack_q && !mmio.ack;
    // only a real frame with the data-read code needs its byte fetched
    assign fetch_due = (launched_code == DATA_READ) && !launched_delay;

    assign mmio.mosi_data = slot_data;
    assign mmio.write     = (phase == PH_IDLE) && slot_full && !mmio.ack;
    assign mmio.read      = (phase == PH_CMD) && ack_fall && fetch_due;

    assign busy = slot_full || mmio.ack;

    always_comb begin
        status_word              = '0;
        status_word[ST_BUSY]     = busy;
        status_word[ST_RX_VALID] = rx_valid;
        status_word[ST_OVERFLOW] = overflow;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            phase          <= PH_IDLE;
            slot_full      <= 1'b0;
            launched_code  <= '0;
            launched_delay <= 1'b0;
            ack_q          <= 1'b0;
            rx_valid       <= 1'b0;
            overflow       <= 1'b0;
        end else begin
            ack_q <= mmio.ack;

            // fill and drain never coincide since a full slot drops writes
            if (cmd_wr && !slot_full) begin
                slot_full <= 1'b1;
            end else if (mmio.write) begin
                slot_full <= 1'b0;
            end

            case (phase)
                PH_IDLE: begin
                    if (mmio.write) begin
                        launched_code  <= slot_data[15:8];
                        launched_delay <= slot_data[`TFT_DELAY_BIT];
                        phase          <= PH_CMD;
                    end
                end
                PH_CMD: begin
                    if (ack_fall) begin
                        phase <= fetch_due ? PH_FETCH : PH_IDLE;
                    end
                end
                PH_FETCH: begin
                    if (ack_fall) begin
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase

            // setting a sticky flag wins over clearing it
            if (phase == PH_FETCH && ack_fall) begin
                rx_valid <= 1'b1;
            end else if (rx_rd) begin
                rx_valid <= 1'b0;
            end

            if (cmd_wr && slot_full) begin
                overflow <= 1'b1;
            end else if (st_rd) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr && !slot_full) begin
            slot_data <= bus_wdata;
        end
        if (phase == PH_FETCH && ack_fall) begin
            rx_byte <= mmio.miso_data[7:0];
        end
        if (bus_ren) begin
            case (bus_addr)
                REG_RXDATA: bus_rdata <= {{(`TFT_DATA_W-8){1'b0}}, rx_byte};
                REG_STATUS: bus_rdata <= status_word;
                default:    bus_rdata <= '0;
            endcase
        end
    end

endmodule

// File: design/tft_spi_master.sv
`timescale 1ns/10ps
`include "tft_defines.svh"

module tft_spi_master import tft_spi_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    tft_mmio_if.engine mmio,
    input  logic       MISO_in,
    output logic       chipSelect,
    output logic       bitData,
    output logic       sclk
);

    localparam logic [4:0] LAST_BIT      = 5'(`TFT_FRAME_BITS - 1);
    // returned byte arrives in the second half of the frame
    localparam logic [4:0] CAPTURE_START = 5'(`TFT_FRAME_BITS - 8);

    spi_state_e state;
    spi_state_e next_state;

    logic [`TFT_FRAME_BITS-1:0] shift_reg;
    logic [`TFT_FRAME_BITS-1:0] next_shift;
    logic [4:0]                 bit_cnt;
    logic [4:0]                 next_bit_cnt;
    logic [15:0]                delay_cnt;
    logic [15:0]                next_delay_cnt;
    logic                       read_flag;
    logic                       next_read_flag;
    logic [7:0]                 miso_reg;
    logic [7:0]                 next_miso;
    logic [15:0]                load_count;
    logic                       load_is_delay;

    assign mmio.miso_data = {{(`TFT_DATA_W-8){1'b0}}, miso_reg};

    assign load_is_delay = mmio.mosi_data[`TFT_DELAY_BIT];
    assign load_count    = mmio.mosi_data[15:0];

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            delay_cnt <= '0;
            read_flag <= 1'b0;
            miso_reg  <= '0;
        end else begin
            state     <= next_state;
            bit_cnt   <= next_bit_cnt;
            delay_cnt <= next_delay_cnt;
            read_flag <= next_read_flag;
            miso_reg  <= next_miso;
        end
    end

    always_ff @(posedge clk) begin
        shift_reg <= next_shift;
    end

    // next state and datapath
    always_comb begin
        next_state     = state;
        next_shift     = shift_reg;
        next_bit_cnt   = bit_cnt;
        next_delay_cnt = delay_cnt;
        next_read_flag = read_flag;
        next_miso      = miso_reg;

        case (state)
            IDLE: begin
                next_bit_cnt = '0;
                if (mmio.write) begin
                    next_state = LOAD;
                end else if (mmio.read) begin
                    next_state = READ;
                end
            end
            LOAD: begin
                next_shift     = mmio.mosi_data[`TFT_FRAME_BITS-1:0];
                next_bit_cnt   = '0;
                next_read_flag = (mmio.mosi_data[15:8] == DATA_READ) && !load_is_delay;
                if (load_is_delay) begin
                    // zero count still waits one cycle
                    next_delay_cnt = (load_count == '0) ? 16'd1 : load_count;
                    next_state     = DELAY;
                end else begin
                    next_state = SHIFT;
                end
            end
            SHIFT: begin
                next_shift   = {shift_reg[`TFT_FRAME_BITS-2:0], 1'b0};
                next_bit_cnt = bit_cnt + 5'd1;
                if (read_flag && bit_cnt >= CAPTURE_START) begin
                    next_miso = {miso_reg[6:0], MISO_in};
                end
                if (bit_cnt == LAST_BIT) begin
                    next_state = IDLE;
                end
            end
            READ: begin
                // byte already sits in miso_reg
                next_state = IDLE;
            end
            DELAY: begin
                next_delay_cnt = delay_cnt - 16'd1;
                if (delay_cnt == 16'd1) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // pin and ack decode from state
    always_comb begin
        sclk       = 1'b1;
        bitData    = 1'b1;
        chipSelect = 1'b1;
        mmio.ack   = 1'b1;

        case (state)
            IDLE: begin
                mmio.ack = 1'b0;
            end
            SHIFT: begin
                // rising sclk lands mid-cycle, while bitData is stable
                sclk       = ~clk;
                bitData    = shift_reg[`TFT_FRAME_BITS-1];
                chipSelect = 1'b0;
            end
            LOAD, READ, DELAY: begin
                mmio.ack = 1'b1;
            end
            default: begin
                mmio.ack = 1'b0;
            end
        endcase
    end

endmodule

// File: design/tft_display_top.sv
`timescale 1ns/10ps
`include "tft_defines.svh"

module tft_display_top (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [`TFT_REG_ADDR_W-1:0] bus_addr,
    input  logic [`TFT_DATA_W-1:0]     bus_wdata,
    input  logic                       bus_wen,
    input  logic                       bus_ren,
    output logic [`TFT_DATA_W-1:0]     bus_rdata,
    input  logic                       MISO_in,
    output logic                       chipSelect,
    output logic                       bitData,
    output logic                       sclk
);

    // command and read-back path between the two blocks
    tft_mmio_if mmio (
        .clk (clk)
    );

    tft_mmio_regs u_regs (
        .clk       (clk),
        .nrst      (nrst),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_wen   (bus_wen),
        .bus_ren   (bus_ren),
        .bus_rdata (bus_rdata),
        .mmio      (mmio.regs)
    );

    // display side pins
    tft_spi_master u_spi (
        .clk        (clk),
        .nrst       (nrst),
        .mmio       (mmio.engine),
        .MISO_in    (MISO_in),
        .chipSelect (chipSelect),
        .bitData    (bitData),
        .sclk       (sclk)
    );

endmodule

// File: sim/ra8875_model.sv
`timescale 1ns/10ps

module ra8875_model import tft_spi_pkg::*; (
    input  logic       sclk,
    input  logic       chip_select,
    input  logic       bit_data,
    input  logic [7:0] ret_byte,
    output logic       miso
);

    // every complete frame, oldest first
    logic [15:0] frames[$];

    logic [15:0] rx_frame;
    logic [7:0]  rx_code;
    int          rx_cnt;

    initial begin
        miso     = 1'b1;
        rx_frame = '0;
        rx_code  = '0;
        rx_cnt   = 0;
    end

    // shift in on rising sclk, store the frame when chip select rises
    always @(posedge sclk or posedge chip_select) begin
        if (chip_select) begin
            if (rx_cnt == 16) begin
                frames.push_back(rx_frame);
            end
            rx_cnt = 0;
        end else if (rx_cnt < 16) begin
            rx_frame = {rx_frame[14:0], bit_data};
            rx_cnt   = rx_cnt + 1;
            if (rx_cnt == 8) begin
                rx_code = rx_frame[7:0];
            end
        end
    end

    // second half of a data read returns the byte, MSB first
    always @(negedge sclk) begin
        if (!chip_select && rx_cnt >= 8 && rx_cnt < 16 && rx_code == DATA_READ) begin
            miso <= ret_byte[15 - rx_cnt];
        end
    end

endmodule

// File: sim/tft_assert.sv
`timescale 1ns/10ps

module tft_spi_assert import tft_spi_pkg::*; (
    input logic       clk,
    input logic       nrst,
    input spi_state_e state,
    input logic       chip_select,
    input logic       ack,
    input logic       write,
    input logic       read
);

    int assert_fails = 0;

    cs_only_in_shift: assert property (@(posedge clk) disable iff (!nrst)
        !chip_select |-> state == SHIFT)
        else begin
            assert_fails++;
            $error("chipSelect low outside SHIFT");
        end

    no_ack_in_idle: assert property (@(posedge clk) disable iff (!nrst)
        state == IDLE |-> !ack)
        else begin
            assert_fails++;
            $error("ack high in IDLE");
        end

    // strobes only toward an idle engine
    no_strobe_while_ack: assert property (@(posedge clk) disable iff (!nrst)
        (write || read) |-> !ack)
        else begin
            assert_fails++;
            $error("write or read strobe while ack is high");
        end

    shift_length: assert property (@(posedge clk) disable iff (!nrst)
        $rose(state == SHIFT) |-> (state == SHIFT) [*16] ##1 (state != SHIFT))
        else begin
            assert_fails++;
            $error("SHIFT run not 16 cycles long");
        end

endmodule

bind tft_spi_master tft_spi_assert u_spi_assert (
    .clk         (clk),
    .nrst        (nrst),
    .state       (state),
    .chip_select (chipSelect),
    .ack         (mmio.ack),
    .write       (mmio.write),
    .read        (mmio.read)
);

// File: sim/tb_tft_display.sv
`timescale 1ns/10ps
`include "tft_defines.svh"

module tb_tft_display import tft_bus_pkg::*, tft_spi_pkg::*; ();

    logic                       clk;
    logic                       nrst;
    logic [`TFT_REG_ADDR_W-1:0] bus_addr;
    logic [`TFT_DATA_W-1:0]     bus_wdata;
    logic                       bus_wen;
    logic                       bus_ren;
    logic [`TFT_DATA_W-1:0]     bus_rdata;
    logic                       miso_in;
    logic                       chip_select;
    logic                       bit_data;
    logic                       sclk;
    logic [7:0]                 ret_byte;
    logic [31:0]                lcg_state;
    int                         errors;
    int                         cs_falls = 0;
    int                         assert_fails;

    tft_display_top u_tft_display_top (
        .clk        (clk),
        .nrst       (nrst),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wen    (bus_wen),
        .bus_ren    (bus_ren),
        .bus_rdata  (bus_rdata),
        .MISO_in    (miso_in),
        .chipSelect (chip_select),
        .bitData    (bit_data),
        .sclk       (sclk)
    );

    ra8875_model u_model (
        .sclk        (sclk),
        .chip_select (chip_select),
        .bit_data    (bit_data),
        .ret_byte    (ret_byte),
        .miso        (miso_in)
    );

    always #4 clk = ~clk;

    always @(negedge chip_select) cs_falls++;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_wen   <= 1'b1;
        @(posedge clk);
        bus_wen <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        bus_addr <= addr;
        bus_ren  <= 1'b1;
        @(posedge clk);
        bus_ren <= 1'b0;
        // rdata is registered on the strobe edge
        @(negedge clk);
        data = bus_rdata;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int          polls;
        polls = 0;
        bus_read(REG_STATUS, st);
        while (st[ST_BUSY] && polls < 100) begin
            bus_read(REG_STATUS, st);
            polls++;
        end
        if (st[ST_BUSY]) begin
            fail_timeout("busy to clear");
        end
    endtask

    task automatic expect_frame(input logic [15:0] exp);
        int waited;
        waited = 0;
        while (u_model.frames.size() == 0 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (u_model.frames.size() == 0) begin
            fail_timeout("a frame at the display model");
        end else begin
            check_eq("model frame", u_model.frames.pop_front(), exp);
        end
    endtask

    task automatic test_reset();
        logic [31:0] st;
        check_eq("chipSelect", chip_select, 1'b1);
        check_eq("sclk", sclk, 1'b1);
        check_eq("bitData", bit_data, 1'b1);
        bus_read(REG_STATUS, st);
        check_eq("status", st, 32'h0);
    endtask

    task automatic test_write_frames();
        logic [31:0] rnd;
        logic [31:0] cmd;
        logic [31:0] st;
        logic [7:0]  code;
        for (int i = 0; i < 4; i++) begin
            rnd  = next_rand();
            code = (i % 2 == 0) ? CMD_WRITE : DATA_WRITE;
            // upper bits are noise, only the low 16 bits go out
            cmd  = {1'b0, rnd[30:16], code, rnd[7:0]};
            bus_write(REG_CMD, cmd);
            wait_idle();
            expect_frame(cmd[15:0]);
        end
        bus_read(REG_STATUS, st);
        check_eq("status.rx_valid", st[ST_RX_VALID], 1'b0);
    endtask

    task automatic test_data_read();
        logic [31:0] rnd;
        logic [31:0] cmd;
        logic [31:0] st;
        logic [31:0] rd;
        rnd      = next_rand();
        ret_byte <= rnd[23:16];
        cmd      = {16'h0, DATA_READ, rnd[7:0]};
        bus_write(REG_CMD, cmd);
        wait_idle();
        expect_frame(cmd[15:0]);
        bus_read(REG_STATUS, st);
        check_eq("status.rx_valid", st[ST_RX_VALID], 1'b1);
        bus_read(REG_RXDATA, rd);
        check_eq("rxdata", rd, {24'h0, rnd[23:16]});
        bus_read(REG_STATUS, st);
        check_eq("status.rx_valid after rxdata read", st[ST_RX_VALID], 1'b0);
    endtask

    task automatic test_delay();
        logic [31:0] rnd;
        logic [31:0] cmd;
        logic [31:0] st;
        int          falls_before;
        cmd                 = 32'h0;
        cmd[`TFT_DELAY_BIT] = 1'b1;
        cmd[15:0]           = 16'd40;
        falls_before        = cs_falls;
        bus_write(REG_CMD, cmd);
        bus_read(REG_STATUS, st);
        check_eq("status.busy during delay", st[ST_BUSY], 1'b1);
        wait_idle();
        check_eq("chipSelect falls during delay", cs_falls - falls_before, 0);
        check_eq("frames during delay", u_model.frames.size(), 0);
        // engine must still send frames after the delay
        rnd = next_rand();
        cmd = {16'h0, CMD_WRITE, rnd[7:0]};
        bus_write(REG_CMD, cmd);
        wait_idle();
        expect_frame(cmd[15:0]);
    endtask

    task automatic test_overflow();
        logic [31:0] rnd;
        logic [31:0] st;
        logic [31:0] cmds [3];
        for (int i = 0; i < 3; i++) begin
            rnd     = next_rand();
            cmds[i] = {16'h0, CMD_WRITE, rnd[7:0]};
            bus_write(REG_CMD, cmds[i]);
        end
        bus_read(REG_STATUS, st);
        check_eq("status.overflow", st[ST_OVERFLOW], 1'b1);
        bus_read(REG_STATUS, st);
        check_eq("status.overflow after status read", st[ST_OVERFLOW], 1'b0);
        wait_idle();
        expect_frame(cmds[0][15:0]);
        expect_frame(cmds[1][15:0]);
        // third write was dropped
        check_eq("frames left after overflow", u_model.frames.size(), 0);
    endtask

    initial begin
        clk       = 1'b0;
        nrst      = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_wen   = 1'b0;
        bus_ren   = 1'b0;
        ret_byte  = '0;
        lcg_state = 32'h6c44882c;
        errors    = 0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);

        test_reset();
        test_write_frames();
        test_data_read();
        test_delay();
        test_overflow();

        assert_fails = u_tft_display_top.u_spi.u_spi_assert.assert_fails;
        $display("check errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/tft_bus_pkg.sv
design/tft_spi_pkg.sv
design/tft_mmio_if.sv
design/tft_mmio_regs.sv
design/tft_spi_master.sv
design/tft_display_top.sv
sim/ra8875_model.sv
sim/tft_assert.sv
sim/tb_tft_display.sv

// File: Bender.yml
package:
  name: tft_display

sources:
  - include_dirs:
      - design
    files:
      - design/tft_bus_pkg.sv
      - design/tft_spi_pkg.sv
      - design/tft_mmio_if.sv
      - design/tft_mmio_regs.sv
      - design/tft_spi_master.sv
      - design/tft_display_top.sv
      - target: simulation
        files:
          - sim/ra8875_model.sv
          - sim/tft_assert.sv
          - sim/tb_tft_display.sv
